/* hdl/ex_pkg.sv */
// ------------------------------
// Execute stage package
// Widths, ALU and branch opcodes, trap constants
// Stage structs and the micro-op union
// ------------------------------

package ex_pkg;

// Widths
// ------------------------------
localparam int XLEN         = 32;       // Data word
localparam int REG_W        = 5;        // Register address
localparam int UOP_W        = 5;        // Micro-op code
localparam int SHAMT_W      = 5;        // Shift amount, log2 of XLEN
localparam int TRAP_CAUSE_W = 6;        // Trap cause field
localparam int SIZE_W       = 2;        // Instruction size
localparam int INSTR_W      = 32;       // Raw instruction word

typedef logic [XLEN-1:0]  xlen_t;       // Data word
typedef logic [REG_W-1:0] reg_addr_t;   // Register address

// One-hot functional unit select
typedef struct packed {
    logic alu;                          // Integer ALU
    logic lsu;                          // Load/store address
    logic cfu;                          // Branch and jump
    logic csr;                          // CSR pass-through
} fu_t;

// ALU view of the micro-op
// ------------------------------
typedef enum logic [UOP_W-1:0] {
    ALU_ADD  = 5'd1,
    ALU_SUB  = 5'd2,
    ALU_XOR  = 5'd3,
    ALU_OR   = 5'd4,
    ALU_AND  = 5'd5,
    ALU_SLL  = 5'd6,
    ALU_SRL  = 5'd7,
    ALU_SRA  = 5'd8,
    ALU_ROR  = 5'd9,
    ALU_ROL  = 5'd10,
    ALU_SLT  = 5'd11,
    ALU_SLTU = 5'd12
} alu_op_e;

// Branch view of the micro-op
// ------------------------------
localparam logic [1:0] CFU_CLASS_COND = 2'b00;   // Conditional branch
localparam logic [1:0] CFU_CLASS_JUMP = 2'b10;   // Unconditional jump

localparam logic [2:0] CFU_BEQ  = 3'd1;          // Condition kinds
localparam logic [2:0] CFU_BNE  = 3'd2;
localparam logic [2:0] CFU_BLT  = 3'd3;
localparam logic [2:0] CFU_BGE  = 3'd4;
localparam logic [2:0] CFU_BLTU = 3'd5;
localparam logic [2:0] CFU_BGEU = 3'd6;

localparam logic [2:0] CFU_JALI = 3'd1;          // Jump kinds
localparam logic [2:0] CFU_JALR = 3'd2;
localparam logic [2:0] CFU_JMP  = 3'd4;

// Rewritten conditional branch codes, class 2'b11
localparam logic [UOP_W-1:0] CFU_TAKEN     = 5'b11001;
localparam logic [UOP_W-1:0] CFU_NOT_TAKEN = 5'b11000;

typedef struct packed {
    logic [1:0] cls;                    // Branch class
    logic [2:0] kind;                   // Condition or jump kind
} cfu_view_t;

// LSU view of the micro-op
typedef struct packed {
    logic       load;                   // Load access
    logic       store;                  // Store access
    logic [2:0] spare;                  // Width bits, unused here
} lsu_view_t;

// One micro-op word, decoded per unit
typedef union packed {
    alu_op_e   alu;
    cfu_view_t cfu;
    lsu_view_t lsu;
} uop_u;

// Stage bundles
// ------------------------------
typedef struct packed {
    reg_addr_t          rd;             // Destination register
    xlen_t              opr_a;          // Operand A
    xlen_t              opr_b;          // Operand B
    xlen_t              opr_c;          // Operand C
    uop_u               uop;            // Micro-op
    fu_t                fu;             // Functional unit
    logic               trap;           // Raise a trap
    logic [SIZE_W-1:0]  size;           // Instruction size
    logic [INSTR_W-1:0] instr;          // Instruction word
} s2_in_t;

typedef struct packed {
    reg_addr_t          rd;
    xlen_t              opr_a;          // Result or address
    xlen_t              opr_b;          // Store data, CSR data or trap cause
    uop_u               uop;
    fu_t                fu;
    logic               trap;
    logic [SIZE_W-1:0]  size;
    logic [INSTR_W-1:0] instr;
} s3_out_t;

typedef struct packed {
    reg_addr_t rd;                      // Forwarded destination
    xlen_t     wdata;                   // Forwarded write data
    logic      load;                    // Load in flight
    logic      csr;                     // CSR op in flight
} fwd_t;

typedef struct packed {
    logic eq;                           // lhs == rhs
    logic lt_signed;                    // lhs < rhs, signed
    logic lt_unsigned;                  // lhs < rhs, unsigned
} alu_flags_t;

endpackage

/* hdl/ex_alu.sv */
// ------------------------------
// Integer ALU
// Decode, adder, logic ops, shift/rotate, compares
// ------------------------------

module ex_alu (
    input  ex_pkg::uop_u       i_uop,       // Micro-op, ALU view
    input  logic               i_is_alu,    // ALU unit selected
    input  ex_pkg::xlen_t      i_lhs,       // Left operand
    input  ex_pkg::xlen_t      i_rhs,       // Right operand
    output ex_pkg::xlen_t      o_result,    // ALU result
    output ex_pkg::xlen_t      o_sum,       // Adder output
    output ex_pkg::alu_flags_t o_flags      // Comparator flags
);

// Opcode decode
// ------------------------------
ex_pkg::alu_op_e op;
logic op_add;
logic op_sub;
logic op_xor;
logic op_or;
logic op_and;
logic op_shf;
logic op_rot;
logic op_left;
logic op_arith;
logic op_slt;
logic op_sltu;

assign op       = i_uop.alu;
assign op_add   = i_is_alu && (op == ex_pkg::ALU_ADD);
assign op_sub   = i_is_alu && (op == ex_pkg::ALU_SUB);
assign op_xor   = i_is_alu && (op == ex_pkg::ALU_XOR);
assign op_or    = i_is_alu && (op == ex_pkg::ALU_OR);
assign op_and   = i_is_alu && (op == ex_pkg::ALU_AND);
assign op_shf   = i_is_alu && (op == ex_pkg::ALU_SLL ||
                               op == ex_pkg::ALU_SRL ||
                               op == ex_pkg::ALU_SRA);
assign op_rot   = i_is_alu && (op == ex_pkg::ALU_ROR ||
                               op == ex_pkg::ALU_ROL);
assign op_left  = i_is_alu && (op == ex_pkg::ALU_SLL ||
                               op == ex_pkg::ALU_ROL);   // Reversed operand
assign op_arith = i_is_alu && (op == ex_pkg::ALU_SRA);
assign op_slt   = i_is_alu && (op == ex_pkg::ALU_SLT);
assign op_sltu  = i_is_alu && (op == ex_pkg::ALU_SLTU);

// Adder
// ------------------------------
ex_pkg::xlen_t rhs_add;
ex_pkg::xlen_t adder;

assign rhs_add = i_rhs ^ {ex_pkg::XLEN{op_sub}};         // Invert for sub
assign adder   = i_lhs + rhs_add + ex_pkg::xlen_t'(op_sub); // Carry in on sub
assign o_sum   = adder;                                   // Plain sum unless sub

// Comparators, always live for branches
assign o_flags.eq          = (i_lhs == i_rhs);
assign o_flags.lt_signed   = ($signed(i_lhs) < $signed(i_rhs));
assign o_flags.lt_unsigned = (i_lhs < i_rhs);

// Shifter
// ------------------------------
function automatic ex_pkg::xlen_t bit_rev(input ex_pkg::xlen_t v);
    ex_pkg::xlen_t r;
    for (int i = 0; i < ex_pkg::XLEN; i++) begin
        r[i] = v[ex_pkg::XLEN-1-i];
    end
    return r;
endfunction

logic [ex_pkg::SHAMT_W-1:0]  shamt;
ex_pkg::xlen_t               shf_in;
ex_pkg::xlen_t               shf_fill;
logic [2*ex_pkg::XLEN-1:0]   shf_wide;
ex_pkg::xlen_t               shf_res;

assign shamt    = i_rhs[ex_pkg::SHAMT_W-1:0];
assign shf_in   = op_left ? bit_rev(i_lhs) : i_lhs;      // Left is reversed right
assign shf_fill = op_rot   ? shf_in                         :  // Wrap around
                  op_arith ? {ex_pkg::XLEN{i_lhs[ex_pkg::XLEN-1]}} :  // Sign fill
                             '0;
assign shf_wide = {shf_fill, shf_in} >> shamt;
assign shf_res  = op_left ? bit_rev(shf_wide[ex_pkg::XLEN-1:0]) :
                            shf_wide[ex_pkg::XLEN-1:0];

// Result mux
// ------------------------------
assign o_result =
    {ex_pkg::XLEN{op_add || op_sub}} & adder                         |
    {ex_pkg::XLEN{op_xor}}           & (i_lhs ^ i_rhs)               |
    {ex_pkg::XLEN{op_or}}            & (i_lhs | i_rhs)               |
    {ex_pkg::XLEN{op_and}}           & (i_lhs & i_rhs)               |
    {ex_pkg::XLEN{op_shf || op_rot}} & shf_res                       |
    {ex_pkg::XLEN{op_slt}}  & ex_pkg::xlen_t'(o_flags.lt_signed)     |
    {ex_pkg::XLEN{op_sltu}} & ex_pkg::xlen_t'(o_flags.lt_unsigned);

endmodule

/* hdl/ex_branch.sv */
// ------------------------------
// Branch resolution
// Condition check, uop rewrite, target align
// ------------------------------

module ex_branch (
    input  ex_pkg::uop_u       i_uop,       // Micro-op, branch view
    input  logic               i_is_cfu,    // Branch unit selected
    input  ex_pkg::alu_flags_t i_flags,     // Comparator flags
    input  ex_pkg::xlen_t      i_sum,       // rs1 + imm for jalr
    input  ex_pkg::xlen_t      i_opr_c,     // Precomputed target
    output ex_pkg::uop_u       o_uop,       // Rewritten micro-op
    output ex_pkg::xlen_t      o_target     // Aligned target
);

logic cond;
logic jalr;
logic taken;

assign cond = i_is_cfu && (i_uop.cfu.cls == ex_pkg::CFU_CLASS_COND);
assign jalr = i_is_cfu && (i_uop.cfu.cls == ex_pkg::CFU_CLASS_JUMP) &&
              (i_uop.cfu.kind == ex_pkg::CFU_JALR);

// Condition evaluation
// ------------------------------
always_comb begin
    case (i_uop.cfu.kind)
        ex_pkg::CFU_BEQ:  taken =  i_flags.eq;
        ex_pkg::CFU_BNE:  taken = !i_flags.eq;
        ex_pkg::CFU_BLT:  taken =  i_flags.lt_signed;
        ex_pkg::CFU_BGE:  taken = !i_flags.lt_signed;
        ex_pkg::CFU_BLTU: taken =  i_flags.lt_unsigned;
        ex_pkg::CFU_BGEU: taken = !i_flags.lt_unsigned;
        default:          taken = 1'b0;               // Unknown kind
    endcase
end

// Micro-op rewrite
always_comb begin
    o_uop = i_uop;                                    // Jumps and others pass
    if (cond) begin
        o_uop.cfu = taken ? ex_pkg::CFU_TAKEN : ex_pkg::CFU_NOT_TAKEN;
    end
end

// Target, bit 0 always cleared
assign o_target = jalr ? {i_sum[ex_pkg::XLEN-1:1], 1'b0} :
                         {i_opr_c[ex_pkg::XLEN-1:1], 1'b0};

endmodule

/* hdl/ex_result_select.sv */
// ------------------------------
// Result select
// Per-unit operands, trap cause, opr_b load enable
// Forwarding bundle
// ------------------------------

module ex_result_select (
    input  ex_pkg::s2_in_t  i_s2,           // Stage input
    input  ex_pkg::xlen_t   i_alu_result,   // ALU result
    input  ex_pkg::xlen_t   i_sum,          // Adder sum, LSU address
    input  ex_pkg::uop_u    i_cfu_uop,      // Micro-op after branch rewrite
    input  ex_pkg::xlen_t   i_target,       // Branch target
    output ex_pkg::s3_out_t o_next,         // Next stage register value
    output logic            o_opr_b_load,   // Replace stored operand B
    output ex_pkg::fwd_t    o_fwd           // Forwarding bundle
);

// Unit decode
// ------------------------------
ex_pkg::fu_t fu;
logic        lsu_load;
logic        lsu_store;

assign fu        = i_s2.fu;
assign lsu_load  = fu.lsu && i_s2.uop.lsu.load;
assign lsu_store = fu.lsu && i_s2.uop.lsu.store;

// Operand A
// ------------------------------
ex_pkg::xlen_t opr_a;

assign opr_a = {ex_pkg::XLEN{fu.alu}} & i_alu_result |       // ALU result
               {ex_pkg::XLEN{fu.lsu}} & i_sum        |       // Access address
               {ex_pkg::XLEN{fu.cfu}} & i_target     |       // Branch target
               {ex_pkg::XLEN{fu.csr}} & i_s2.opr_a;          // CSR source

// Operand B and trap cause
// ------------------------------
logic [ex_pkg::TRAP_CAUSE_W-1:0] trap_cause;
ex_pkg::xlen_t                   opr_b;

// Trap cause is rd zero extended
assign trap_cause = {{(ex_pkg::TRAP_CAUSE_W-ex_pkg::REG_W){1'b0}}, i_s2.rd};

assign opr_b = i_s2.trap ?
    {{(ex_pkg::XLEN-ex_pkg::TRAP_CAUSE_W){1'b0}}, trap_cause} :
    {ex_pkg::XLEN{lsu_store || fu.csr}} & i_s2.opr_c;        // Store or CSR data

assign o_opr_b_load = lsu_store || fu.csr || i_s2.trap;

// Next register value
// ------------------------------
assign o_next.rd    = i_s2.rd;
assign o_next.opr_a = opr_a;
assign o_next.opr_b = opr_b;
assign o_next.uop   = i_cfu_uop;            // Non-branch uops unchanged
assign o_next.fu    = fu;
assign o_next.trap  = i_s2.trap;
assign o_next.size  = i_s2.size;
assign o_next.instr = i_s2.instr;

// Forwarding
// ------------------------------
assign o_fwd.rd    = i_s2.rd;
assign o_fwd.wdata = opr_a;                 // Same value as the write data
assign o_fwd.load  = lsu_load;
assign o_fwd.csr   = fu.csr;

endmodule

/* hdl/ex_pipe_reg.sv */
// ------------------------------
// Execute stage register
// Valid, busy, flush and opr_b hold
// ------------------------------

module ex_pipe_reg (
    input  logic            g_clk,
    input  logic            g_resetn,       // Sync, active low
    input  logic            i_flush,        // Kill the stage output
    input  ex_pkg::s3_out_t i_next,         // Value to capture
    input  logic            i_valid,        // Upstream valid
    input  logic            i_opr_b_load,   // Capture operand B too
    input  logic            i_busy,         // Downstream busy
    output logic            o_busy,         // Upstream must hold
    output ex_pkg::s3_out_t o_s3,           // Registered stage output
    output logic            o_valid         // Registered valid
);

logic            accept;
ex_pkg::s3_out_t s3_load;

assign o_busy = o_valid && i_busy;          // Stalled output blocks input
assign accept = i_valid && !o_busy && !i_flush;  // Flush beats load

// Operand B held unless the op supplies it
always_comb begin
    s3_load = i_next;
    if (!i_opr_b_load) begin
        s3_load.opr_b = o_s3.opr_b;
    end
end

// Valid flag
// ------------------------------
always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
        o_valid <= 1'b0;
    end else if (i_flush) begin
        o_valid <= 1'b0;
    end else if (!o_busy) begin
        o_valid <= i_valid;                 // Falls on a bubble
    end
end

// Data
// ------------------------------
always_ff @(posedge g_clk) begin
    if (!g_resetn) begin
        o_s3 <= '0;
    end else if (accept) begin
        o_s3 <= s3_load;
    end
end

endmodule

/* hdl/ex_stage.sv */
// ------------------------------
// Execute stage top level
// ALU, branch, result select, stage register
// ------------------------------

module ex_stage (
    input  logic            g_clk,
    input  logic            g_resetn,       // Sync, active low
    input  logic            i_flush,        // Flush the stage
    input  ex_pkg::s2_in_t  i_s2,           // Decoded instruction in
    input  logic            i_s2_valid,     // Input valid
    output logic            o_s2_busy,      // Stage stalled
    input  logic            i_s3_busy,      // Next stage stalled
    output ex_pkg::s3_out_t o_s3,           // Registered result
    output logic            o_s3_valid,     // Result valid
    output ex_pkg::fwd_t    o_fwd           // Same-cycle forwarding
);

// Internal nets
// ------------------------------
ex_pkg::xlen_t      alu_result;
ex_pkg::xlen_t      sum;
ex_pkg::alu_flags_t flags;
ex_pkg::uop_u       cfu_uop;
ex_pkg::xlen_t      target;
ex_pkg::s3_out_t    next;
logic               opr_b_load;

ex_alu u_alu (
    .i_uop    (i_s2.uop),
    .i_is_alu (i_s2.fu.alu),
    .i_lhs    (i_s2.opr_a),
    .i_rhs    (i_s2.opr_b),
    .o_result (alu_result),
    .o_sum    (sum),
    .o_flags  (flags)
);

ex_branch u_branch (
    .i_uop    (i_s2.uop),
    .i_is_cfu (i_s2.fu.cfu),
    .i_flags  (flags),
    .i_sum    (sum),
    .i_opr_c  (i_s2.opr_c),
    .o_uop    (cfu_uop),
    .o_target (target)
);

ex_result_select u_result_select (
    .i_s2         (i_s2),
    .i_alu_result (alu_result),
    .i_sum        (sum),
    .i_cfu_uop    (cfu_uop),
    .i_target     (target),
    .o_next       (next),
    .o_opr_b_load (opr_b_load),
    .o_fwd        (o_fwd)
);

ex_pipe_reg u_pipe_reg (
    .g_clk        (g_clk),
    .g_resetn     (g_resetn),
    .i_flush      (i_flush),
    .i_next       (next),
    .i_valid      (i_s2_valid),
    .i_opr_b_load (opr_b_load),
    .i_busy       (i_s3_busy),
    .o_busy       (o_s2_busy),
    .o_s3         (o_s3),
    .o_valid      (o_s3_valid)
);

endmodule

/* verif/tb_ex_stage.sv */
// ------------------------------
// Execute stage testbench
// Reference model, stimulus table, compare tasks
// Cycle-count timeout
// ------------------------------

module tb_ex_stage;

logic               g_clk;
logic               g_resetn;
logic               i_flush;
ex_pkg::s2_in_t     i_s2;
logic               i_s2_valid;
logic               o_s2_busy;
logic               i_s3_busy;
ex_pkg::s3_out_t    o_s3;
logic               o_s3_valid;
ex_pkg::fwd_t       o_fwd;

ex_stage u_ex_stage (
    .g_clk      (g_clk),
    .g_resetn   (g_resetn),
    .i_flush    (i_flush),
    .i_s2       (i_s2),
    .i_s2_valid (i_s2_valid),
    .o_s2_busy  (o_s2_busy),
    .i_s3_busy  (i_s3_busy),
    .o_s3       (o_s3),
    .o_s3_valid (o_s3_valid),
    .o_fwd      (o_fwd)
);

always #20 g_clk = ~g_clk;                  // 40 unit period

// Stimulus table and bookkeeping
// ------------------------------
string           tab_name  [$];
ex_pkg::s2_in_t  tab_in    [$];
logic            tab_valid [$];
logic            tab_flush [$];
int              tab_busy  [$];             // Stall cycles before release
ex_pkg::xlen_t   tab_a     [$];             // o_s3 after the entry
ex_pkg::xlen_t   tab_b     [$];
ex_pkg::uop_u    tab_uop   [$];
ex_pkg::s2_in_t  tab_held  [$];             // Last accepted input
ex_pkg::fwd_t    tab_fwd   [$];             // Same-cycle forwarding

ex_pkg::xlen_t   m_a;                       // Model of the stage register
ex_pkg::xlen_t   m_b;
ex_pkg::uop_u    m_uop;
ex_pkg::s2_in_t  m_held;                    // Source of the carried fields
integer          seed;
string           cur_name;
int              test_errs;
int              errors;
int              tests;
int              failed;
int              cycle_count;
int              limit;
logic [2:0]      br_kind [6];
string           br_name [6];

// Reference model
// ------------------------------
function automatic ex_pkg::xlen_t alu_ref(input ex_pkg::alu_op_e op,
                                          input ex_pkg::xlen_t a, input ex_pkg::xlen_t b);
    logic [63:0]   wide;
    logic [4:0]    sh;
    ex_pkg::xlen_t r;
    sh   = b[4:0];                          // Low five bits only
    wide = {a, a};                          // Doubled word for rotates
    case (op)
        ex_pkg::ALU_ADD:  r = a + b;
        ex_pkg::ALU_SUB:  r = a - b;
        ex_pkg::ALU_XOR:  r = a ^ b;
        ex_pkg::ALU_OR:   r = a | b;
        ex_pkg::ALU_AND:  r = a & b;
        ex_pkg::ALU_SLL:  r = a << sh;
        ex_pkg::ALU_SRL:  r = a >> sh;
        ex_pkg::ALU_SRA:  r = $signed(a) >>> sh;
        ex_pkg::ALU_ROR:  r = 32'(wide >> sh);
        ex_pkg::ALU_ROL:  r = 32'((wide << sh) >> 32);
        ex_pkg::ALU_SLT:  r = {31'b0, $signed(a) < $signed(b)};
        ex_pkg::ALU_SLTU: r = {31'b0, a < b};
        default:          r = '0;
    endcase
    return r;
endfunction

function automatic logic cond_ref(input logic [2:0] kind,
                                  input ex_pkg::xlen_t a, input ex_pkg::xlen_t b);
    case (kind)
        ex_pkg::CFU_BEQ:  return a == b;
        ex_pkg::CFU_BNE:  return a != b;
        ex_pkg::CFU_BLT:  return $signed(a) < $signed(b);
        ex_pkg::CFU_BGE:  return !($signed(a) < $signed(b));
        ex_pkg::CFU_BLTU: return a < b;
        ex_pkg::CFU_BGEU: return !(a < b);
        default:          return 1'b0;
    endcase
endfunction

task automatic model_stage(input ex_pkg::s2_in_t s, output ex_pkg::xlen_t a,
                           output ex_pkg::xlen_t b, output ex_pkg::uop_u u,
                           output ex_pkg::fwd_t f);
    ex_pkg::xlen_t sum;
    sum = s.opr_a + s.opr_b;
    a   = '0;
    b   = m_b;                              // Held unless replaced
    u   = s.uop;
    if (s.fu.alu) a = alu_ref(s.uop.alu, s.opr_a, s.opr_b);
    if (s.fu.lsu) a = sum;                  // Access address
    if (s.fu.cfu) begin
        if (s.uop.cfu.cls == ex_pkg::CFU_CLASS_COND) begin
            u = cond_ref(s.uop.cfu.kind, s.opr_a, s.opr_b) ?
                ex_pkg::CFU_TAKEN : ex_pkg::CFU_NOT_TAKEN;
        end
        if (s.uop.cfu.cls == ex_pkg::CFU_CLASS_JUMP && s.uop.cfu.kind == ex_pkg::CFU_JALR)
            a = {sum[ex_pkg::XLEN-1:1], 1'b0};
        else
            a = {s.opr_c[ex_pkg::XLEN-1:1], 1'b0};
    end
    if (s.fu.csr) a = s.opr_a;
    if ((s.fu.lsu && s.uop.lsu.store) || s.fu.csr) b = s.opr_c;
    if (s.trap) b = ex_pkg::xlen_t'(s.rd);  // Cause is rd zero extended
    f.rd    = s.rd;
    f.wdata = a;
    f.load  = s.fu.lsu && s.uop.lsu.load;
    f.csr   = s.fu.csr;
endtask

// Input builders
// ------------------------------
function automatic ex_pkg::s2_in_t make_base(input ex_pkg::xlen_t a, input ex_pkg::xlen_t b,
                                              input ex_pkg::xlen_t c);
    ex_pkg::s2_in_t s;
    s       = '0;
    s.rd    = ex_pkg::reg_addr_t'($random(seed));
    s.opr_a = a;
    s.opr_b = b;
    s.opr_c = c;
    s.size  = 2'b11;
    s.instr = $random(seed);
    return s;
endfunction

function automatic ex_pkg::s2_in_t make_alu(input ex_pkg::alu_op_e op,
                                             input ex_pkg::xlen_t a, input ex_pkg::xlen_t b);
    ex_pkg::s2_in_t s;
    s         = make_base(a, b, $random(seed));
    s.uop.alu = op;
    s.fu.alu  = 1'b1;
    return s;
endfunction

function automatic ex_pkg::s2_in_t make_cfu(input logic [1:0] cls, input logic [2:0] kind,
                                             input ex_pkg::xlen_t a, input ex_pkg::xlen_t b,
                                             input ex_pkg::xlen_t c);
    ex_pkg::s2_in_t s;
    s              = make_base(a, b, c);
    s.uop.cfu.cls  = cls;
    s.uop.cfu.kind = kind;
    s.fu.cfu       = 1'b1;
    return s;
endfunction

function automatic ex_pkg::s2_in_t make_lsu(input logic ld, input logic st,
                                             input ex_pkg::xlen_t a, input ex_pkg::xlen_t b);
    ex_pkg::s2_in_t s;
    s               = make_base(a, b, $random(seed));
    s.uop.lsu.load  = ld;
    s.uop.lsu.store = st;
    s.fu.lsu        = 1'b1;
    return s;
endfunction

task automatic add_entry(input string name, input ex_pkg::s2_in_t s, input logic valid,
                         input logic flush, input int busy);
    ex_pkg::xlen_t a;
    ex_pkg::xlen_t b;
    ex_pkg::uop_u  u;
    ex_pkg::fwd_t  f;
    model_stage(s, a, b, u, f);
    if (valid && !flush) begin              // Only accepted inputs load
        m_a    = a;
        m_b    = b;
        m_uop  = u;
        m_held = s;
    end
    tab_name.push_back(name);
    tab_in.push_back(s);
    tab_valid.push_back(valid);
    tab_flush.push_back(flush);
    tab_busy.push_back(busy);
    tab_a.push_back(m_a);
    tab_b.push_back(m_b);
    tab_uop.push_back(m_uop);
    tab_held.push_back(m_held);
    tab_fwd.push_back(f);
endtask

// Compare tasks
// ------------------------------
task automatic check_word(input string what, input ex_pkg::xlen_t exp, input ex_pkg::xlen_t act);
    if (act !== exp) begin
        test_errs++;
        $display("[ERROR] %s %s: expected %h, actual %h", cur_name, what, exp, act);
    end
endtask

task automatic check_uop(input ex_pkg::uop_u exp, input ex_pkg::uop_u act);
    if (act !== exp) begin
        test_errs++;
        $display("[ERROR] %s uop: expected %h, actual %h", cur_name, exp, act);
    end
endtask

task automatic check_fwd(input ex_pkg::fwd_t exp, input ex_pkg::fwd_t act);
    string exp_txt;
    string act_txt;
    exp_txt = $sformatf("rd=%0d wdata=%h load=%b csr=%b",
                        exp.rd, exp.wdata, exp.load, exp.csr);
    act_txt = $sformatf("rd=%0d wdata=%h load=%b csr=%b",
                        act.rd, act.wdata, act.load, act.csr);
    if (act !== exp) begin
        test_errs++;
        $display("[ERROR] %s fwd: expected %s, actual %s", cur_name, exp_txt, act_txt);
    end
endtask

// Fields carried unchanged from the accepted input
task automatic check_passthru(input ex_pkg::s2_in_t exp, input ex_pkg::s3_out_t act);
    string exp_txt;
    string act_txt;
    exp_txt = $sformatf("rd=%0d fu=%b trap=%b size=%b instr=%h",
                        exp.rd, exp.fu, exp.trap, exp.size, exp.instr);
    act_txt = $sformatf("rd=%0d fu=%b trap=%b size=%b instr=%h",
                        act.rd, act.fu, act.trap, act.size, act.instr);
    if (act.rd !== exp.rd || act.fu !== exp.fu || act.trap !== exp.trap ||
        act.size !== exp.size || act.instr !== exp.instr) begin
        test_errs++;
        $display("[ERROR] %s fields: expected %s, actual %s", cur_name, exp_txt, act_txt);
    end
endtask

task automatic check_valid(input string what, input logic exp, input logic act);
    if (act !== exp) begin
        test_errs++;
        $display("[ERROR] %s %s: expected %b, actual %b", cur_name, what, exp, act);
    end
endtask

task automatic finish_test();
    tests++;
    errors += test_errs;
    if (test_errs == 0) begin
        $display("ok    %s", cur_name);
    end else begin
        failed++;
        $display("fail  %s (%0d mismatches)", cur_name, test_errs);
    end
endtask

// Timeout
// ------------------------------
initial begin
    cycle_count = 0;
    wait (limit != 0);
    while (cycle_count < limit) begin
        @(posedge g_clk);
        cycle_count++;
    end
    $display("Timeout: run still going after %0d cycles", limit);
    $display("TEST FAILED");
    $finish;
end

// Main sequence
// ------------------------------
initial begin
    ex_pkg::alu_op_e op;
    ex_pkg::s2_in_t  s;
    logic            ready;
    g_clk      = 1'b0;
    g_resetn   = 1'b0;
    i_flush    = 1'b0;
    i_s2       = '0;
    i_s2_valid = 1'b0;
    i_s3_busy  = 1'b0;
    limit      = 0;
    errors     = 0;
    tests      = 0;
    failed     = 0;
    seed       = 21;
    m_a        = '0;                        // Register is zero after reset
    m_b        = '0;
    m_uop      = '0;
    m_held     = '0;
    br_kind = '{ex_pkg::CFU_BEQ, ex_pkg::CFU_BNE, ex_pkg::CFU_BLT,
                ex_pkg::CFU_BGE, ex_pkg::CFU_BLTU, ex_pkg::CFU_BGEU};
    br_name = '{"beq", "bne", "blt", "bge", "bltu", "bgeu"};

    // Every ALU opcode on random operands
    op = op.first();
    repeat (op.num()) begin
        add_entry($sformatf("alu_%s_rand", op.name()),
                  make_alu(op, $random(seed), $random(seed)), 1'b1, 1'b0, 0);
        op = op.next();
    end
    // Edge operands
    add_entry("alu_sll_0",     make_alu(ex_pkg::ALU_SLL,  32'h8000_0001, 32'd0),  1, 0, 0);
    add_entry("alu_sll_31",    make_alu(ex_pkg::ALU_SLL,  32'h0000_0003, 32'd31), 1, 0, 0);
    add_entry("alu_srl_31",    make_alu(ex_pkg::ALU_SRL,  32'h8000_0000, 32'd31), 1, 0, 0);
    add_entry("alu_sra_neg",   make_alu(ex_pkg::ALU_SRA,  32'h8000_00f0, 32'd4),  1, 0, 0);
    add_entry("alu_sra_31",    make_alu(ex_pkg::ALU_SRA,  32'h8000_0000, 32'd31), 1, 0, 0);
    add_entry("alu_ror_0",     make_alu(ex_pkg::ALU_ROR,  32'hdead_beef, 32'd0),  1, 0, 0);
    add_entry("alu_rol_31",    make_alu(ex_pkg::ALU_ROL,  32'h8000_0001, 32'd31), 1, 0, 0);
    add_entry("alu_slt_sign",  make_alu(ex_pkg::ALU_SLT,  32'hffff_ffff, 32'd1),  1, 0, 0);
    add_entry("alu_sltu_sign", make_alu(ex_pkg::ALU_SLTU, 32'hffff_ffff, 32'd1),  1, 0, 0);
    add_entry("alu_sub_wrap",  make_alu(ex_pkg::ALU_SUB,  32'd0,         32'd1),  1, 0, 0);

    // Conditional branches on equal and sign-split operands
    for (int k = 0; k < 6; k++) begin
        s = make_cfu(ex_pkg::CFU_CLASS_COND, br_kind[k], 32'h1234_5678, 32'h1234_5678,
                     $random(seed));
        add_entry({br_name[k], "_equal"}, s, 1'b1, 1'b0, 0);
        s = make_cfu(ex_pkg::CFU_CLASS_COND, br_kind[k], 32'hffff_ff00, 32'h0000_0100,
                     $random(seed));
        add_entry({br_name[k], "_sign"}, s, 1'b1, 1'b0, 0);
    end
    add_entry("jalr", make_cfu(ex_pkg::CFU_CLASS_JUMP, ex_pkg::CFU_JALR,
                               32'h0000_1235, 32'h0000_0010, 32'h0000_4444), 1, 0, 0);
    add_entry("jali", make_cfu(ex_pkg::CFU_CLASS_JUMP, ex_pkg::CFU_JALI,
                               32'h0000_1000, 32'h0000_0004, 32'h0000_2003), 1, 0, 0);

    // Loads, stores, CSR and trap
    add_entry("store", make_lsu(1'b0, 1'b1, 32'h0000_8000, 32'h0000_0024), 1, 0, 0);
    add_entry("load",  make_lsu(1'b1, 1'b0, 32'h0000_9000, 32'hffff_fffc), 1, 0, 0);
    s        = make_base($random(seed), $random(seed), $random(seed));
    s.fu.csr = 1'b1;
    add_entry("csr", s, 1'b1, 1'b0, 0);
    s      = make_alu(ex_pkg::ALU_ADD, $random(seed), $random(seed));
    s.trap = 1'b1;
    s.rd   = 5'd13;
    add_entry("trap", s, 1'b1, 1'b0, 0);

    // Back-pressure, flush and bubble
    add_entry("busy_hold", make_alu(ex_pkg::ALU_XOR, $random(seed), $random(seed)), 1, 0, 2);
    add_entry("flush", make_lsu(1'b0, 1'b1, $random(seed), $random(seed)), 1'b1, 1'b1, 0);
    add_entry("after_flush", make_alu(ex_pkg::ALU_OR, $random(seed), $random(seed)), 1, 0, 0);
    add_entry("bubble", make_alu(ex_pkg::ALU_AND, $random(seed), $random(seed)), 1'b0, 1'b0, 0);

    limit = 4 * tab_name.size() + 50;

    // Hold reset four cycles and check the cleared stage
    repeat (4) @(posedge g_clk);
    @(negedge g_clk);
    g_resetn  = 1'b1;
    cur_name  = "reset";
    test_errs = 0;
    check_valid("o_s3_valid", 1'b0, o_s3_valid);
    check_valid("o_s2_busy", 1'b0, o_s2_busy);
    check_word("o_s3.opr_a", '0, o_s3.opr_a);
    check_word("o_s3.opr_b", '0, o_s3.opr_b);
    check_uop('0, o_s3.uop);
    check_passthru('0, o_s3);
    finish_test();

    for (int i = 0; i < tab_name.size(); i++) begin
        cur_name   = tab_name[i];
        test_errs  = 0;
        i_s2       = tab_in[i];             // Driven on the falling edge
        i_s2_valid = tab_valid[i];
        i_flush    = tab_flush[i];
        i_s3_busy  = (tab_busy[i] > 0);
        #10;
        check_fwd(tab_fwd[i], o_fwd);
        // Output must hold while downstream stalls
        repeat (tab_busy[i]) begin
            check_valid("o_s2_busy", 1'b1, o_s2_busy);
            @(negedge g_clk);
            check_valid("o_s3_valid", 1'b1, o_s3_valid);
            check_word("o_s3.opr_a held", m_a, o_s3.opr_a);
            check_word("o_s3.opr_b held", m_b, o_s3.opr_b);
            check_uop(m_uop, o_s3.uop);
            check_passthru(m_held, o_s3);
            #10;
        end
        if (tab_busy[i] > 0) begin
            @(negedge g_clk);
            i_s3_busy = 1'b0;
            #10;
        end
        if (tab_valid[i] && !tab_flush[i]) begin
            do begin                        // Wait for the handshake
                ready = !o_s2_busy;
                @(negedge g_clk);
                if (!ready) #10;
            end while (!ready);
            check_valid("o_s3_valid", 1'b1, o_s3_valid);
        end else begin
            @(negedge g_clk);
            check_valid("o_s3_valid", 1'b0, o_s3_valid);
        end
        check_word("o_s3.opr_a", tab_a[i], o_s3.opr_a);
        check_word("o_s3.opr_b", tab_b[i], o_s3.opr_b);
        check_uop(tab_uop[i], o_s3.uop);
        check_passthru(tab_held[i], o_s3);
        m_a    = tab_a[i];                  // Register contents from here on
        m_b    = tab_b[i];
        m_uop  = tab_uop[i];
        m_held = tab_held[i];
        finish_test();
    end

    i_s2_valid = 1'b0;
    $display("Summary: %0d tests, %0d failed, %0d mismatches", tests, failed, errors);
    if (errors == 0) begin
        $display("TEST PASSED");
    end else begin
        $display("TEST FAILED");
    end
    $finish;
end

endmodule

/* tb.f */
hdl/ex_pkg.sv
hdl/ex_alu.sv
hdl/ex_branch.sv
hdl/ex_result_select.sv
hdl/ex_pipe_reg.sv
hdl/ex_stage.sv
verif/tb_ex_stage.sv

/* Makefile */
# Verilator build, run, lint and clean for the execute stage

TOP = tb_ex_stage

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f tb.f -o sim

run: build
	./obj_dir/sim | tee sim.log
	grep -q "TEST PASSED" sim.log

lint:
	verilator --lint-only -Wall --top-module ex_stage \
		hdl/ex_pkg.sv hdl/ex_alu.sv hdl/ex_branch.sv \
		hdl/ex_result_select.sv hdl/ex_pipe_reg.sv hdl/ex_stage.sv

clean:
	rm -rf obj_dir sim.log
